//--- logic/synth_pkg.sv
// shared constants and types for the synth voice, the increment table assumes a 16 bit phase
`default_nettype none

package synth_pkg;

    // channel message status nibbles
    localparam logic [3:0] MIDI_NOTE_OFF = 4'h8;
    localparam logic [3:0] MIDI_NOTE_ON  = 4'h9;
    localparam logic [3:0] MIDI_CTRL     = 4'hB;
    localparam logic [3:0] MIDI_BEND     = 4'hE;

    // controller number for pan
    localparam logic [6:0]  CC_PAN      = 7'd10;
    localparam logic [13:0] BEND_CENTER = 14'd8192;
    localparam int          PHASE_W     = 16;

    // two data bytes, second one on top
    typedef struct packed {
        logic [6:0] msb;
        logic [6:0] lsb;
    } midi_bytes_t;

    // note messages read b, pitch bend reads the whole word
    typedef union packed {
        midi_bytes_t b;
        logic [13:0] bend;
    } midi_data_u;

    // top octave increments, one semitone apart
    function automatic logic [PHASE_W-1:0] semitone_inc(input logic [6:0] key);
        logic [3:0]         note;
        logic [3:0]         oct;
        logic [3:0]         shift;
        logic [PHASE_W-1:0] base;
        note  = 4'(key % 12);
        oct   = 4'(key / 12);
        // keys 120 and up already sit in the top octave
        shift = (oct >= 4'd10) ? 4'd0 : 4'd10 - oct;
        case (note)
            4'd0:    base = 16'd16384;
            4'd1:    base = 16'd17358;
            4'd2:    base = 16'd18390;
            4'd3:    base = 16'd19484;
            4'd4:    base = 16'd20643;
            4'd5:    base = 16'd21870;
            4'd6:    base = 16'd23170;
            4'd7:    base = 16'd24548;
            4'd8:    base = 16'd26008;
            4'd9:    base = 16'd27554;
            4'd10:   base = 16'd29193;
            default: base = 16'd30929;
        endcase
        return base >> shift;
    endfunction

endpackage

`default_nettype wire

//--- logic/midi_msg_if.sv
// one decoded channel message per rdy strobe with no back-pressure
`timescale 1ns/1ps
`default_nettype none

interface midi_msg_if import synth_pkg::*; ();

    // one cycle strobe, cmd and data valid with it
    logic       rdy;
    // status nibble
    logic [3:0] cmd;
    // both data bytes or the bend word
    midi_data_u data;

    // decoder side
    modport src (output rdy, cmd, data);
    // controller side
    modport dst (input rdy, cmd, data);

endinterface

`default_nettype wire

//--- logic/voice_if.sv
// voice state from the controller to the oscillator, tick and restart are single cycle strobes
`timescale 1ns/1ps
`default_nettype none

interface voice_if import synth_pkg::*; ();

    logic               tick;     // sample rate strobe
    logic               gate;     // note held
    logic [PHASE_W-1:0] inc;      // phase step before bend
    logic [13:0]        bend;     // raw 14 bit bend, center 8192
    logic [6:0]         amp_l;
    logic [6:0]         amp_r;
    logic               restart;  // zero the phase on note on

    modport ctl (output tick, gate, inc, bend, amp_l, amp_r, restart);
    modport osc (input tick, gate, inc, bend, amp_l, amp_r, restart);

endinterface

`default_nettype wire

//--- logic/uart_rx.sv
// 8N1 receiver only with no parity and CLKS_PER_BIT of 2 or more
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic       byte_rdy,
    output logic [7:0] byte_data
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;
    localparam int HALF  = (CLKS_PER_BIT / 2 > 0) ? CLKS_PER_BIT / 2 : 1;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic [1:0]       state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;

    // ------------------------------------------------------------------------
    // synchronizer, third flop only for edge detect
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ------------------------------------------------------------------------
    // bit timing fsm, cnt counts down to the next sample point
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            byte_rdy <= 1'b0;
        end else begin
            byte_rdy <= 1'b0;
            case (state)
                S_IDLE: begin
                    // falling edge, start bit begins
                    if (rx_prev && !rx_sync) begin
                        state <= S_START;
                        cnt   <= CNT_W'(HALF - 1);
                    end
                end
                S_START: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (!rx_sync) begin
                        state   <= S_DATA;
                        cnt     <= CNT_W'(CLKS_PER_BIT - 1);
                        bit_idx <= '0;
                    end else begin
                        // glitch, not a real start bit
                        state <= S_IDLE;
                    end
                end
                S_DATA: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        cnt <= CNT_W'(CLKS_PER_BIT - 1);
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        // framing error drops the byte silently
                        byte_rdy <= rx_sync;
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == S_DATA && cnt == '0) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

    assign byte_data = shreg;

endmodule

`default_nettype wire

//--- logic/midi_decoder.sv
// channel messages only with running status, sysex content is parsed and dropped
`timescale 1ns/1ps
`default_nettype none

module midi_decoder import synth_pkg::*; #(
    parameter logic [3:0] MIDI_CH = 4'd0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       byte_rdy,
    input  logic [7:0] byte_data,
    midi_msg_if.src    msg
);

    logic [7:0] status;
    logic       status_vld;
    logic       have_lsb;
    logic [6:0] lsb_q;
    logic       is_status;
    logic       is_realtime;
    logic       one_byte;
    logic       handled;
    logic       emit;

    always_comb begin
        is_status   = byte_data[7];
        is_realtime = byte_data[7:3] == 5'b11111;
        // program change and channel pressure carry one data byte
        one_byte    = status[7:5] == 3'b110;
        handled     = status[7:4] == MIDI_NOTE_OFF || status[7:4] == MIDI_NOTE_ON ||
                      status[7:4] == MIDI_CTRL || status[7:4] == MIDI_BEND;
        // second data byte of a wanted message
        emit        = byte_rdy && !is_status && status_vld && !one_byte && have_lsb &&
                      handled && status[3:0] == MIDI_CH;
    end

    // ------------------------------------------------------------------------
    // running status and data byte phase
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_vld <= 1'b0;
            status     <= '0;
            have_lsb   <= 1'b0;
            msg.rdy    <= 1'b0;
        end else begin
            msg.rdy <= emit;
            if (byte_rdy) begin
                if (is_status) begin
                    // real-time bytes leave everything as it is
                    if (!is_realtime) begin
                        have_lsb <= 1'b0;
                        if (byte_data[7:4] == 4'hF) begin
                            status_vld <= 1'b0;
                        end else begin
                            status_vld <= 1'b1;
                            status     <= byte_data;
                        end
                    end
                end else if (status_vld && !one_byte) begin
                    // lsb then msb, then wait for the next pair
                    have_lsb <= !have_lsb;
                end
            end
        end
    end

    // payload, first data byte and the assembled message
    always_ff @(posedge clk) begin
        if (byte_rdy && !is_status && !have_lsb) begin
            lsb_q <= byte_data[6:0];
        end
        if (emit) begin
            msg.cmd        <= status[7:4];
            msg.data.b.lsb <= lsb_q;
            msg.data.b.msb <= byte_data[6:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/voice_ctrl.sv
// single voice with no note stack so a note off only releases the stored key
`timescale 1ns/1ps
`default_nettype none

module voice_ctrl import synth_pkg::*; #(
    parameter int SMPL_W = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    midi_msg_if.dst msg,
    voice_if.ctl    voice
);

    logic [SMPL_W-1:0] smpl_cnt;
    logic [6:0]        key;
    logic [6:0]        vel;
    logic [6:0]        pan;
    logic              is_on;
    logic              is_off;
    logic              is_pan;
    logic              is_bend;
    logic [6:0]        new_vel;
    logic [6:0]        new_pan;
    logic [13:0]       prod_l;
    logic [13:0]       prod_r;

    // ------------------------------------------------------------------------
    // message decode and amp math
    // ------------------------------------------------------------------------
    always_comb begin
        is_on   = msg.rdy && msg.cmd == MIDI_NOTE_ON && msg.data.b.msb != 7'd0;
        // velocity 0 note on counts as note off
        is_off  = msg.rdy && msg.data.b.lsb == key &&
                  (msg.cmd == MIDI_NOTE_OFF ||
                   (msg.cmd == MIDI_NOTE_ON && msg.data.b.msb == 7'd0));
        is_pan  = msg.rdy && msg.cmd == MIDI_CTRL && msg.data.b.lsb == CC_PAN;
        is_bend = msg.rdy && msg.cmd == MIDI_BEND;
        // fresh velocity on note on and fresh pan on cc 10
        new_vel = is_on ? msg.data.b.msb : vel;
        new_pan = is_pan ? msg.data.b.msb : pan;
        prod_l  = 14'(new_vel) * 14'(7'd127 - new_pan);
        prod_r  = 14'(new_vel) * 14'(new_pan);
    end

    // ------------------------------------------------------------------------
    // voice state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key           <= '0;
            vel           <= '0;
            pan           <= 7'd64;
            voice.gate    <= 1'b0;
            voice.inc     <= '0;
            voice.bend    <= BEND_CENTER;
            voice.amp_l   <= '0;
            voice.amp_r   <= '0;
            voice.restart <= 1'b0;
        end else begin
            voice.restart <= is_on;
            if (is_on) begin
                key        <= msg.data.b.lsb;
                vel        <= msg.data.b.msb;
                voice.inc  <= semitone_inc(msg.data.b.lsb);
                voice.gate <= 1'b1;
            end else if (is_off) begin
                voice.gate <= 1'b0;
            end
            if (is_pan) begin
                pan <= msg.data.b.msb;
            end
            if (is_on || is_pan) begin
                voice.amp_l <= prod_l[13:7];
                voice.amp_r <= prod_r[13:7];
            end
            if (is_bend) begin
                voice.bend <= msg.data.bend;
            end
        end
    end

    // sample rate counter ticks on wrap
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            smpl_cnt <= '0;
        end else begin
            smpl_cnt <= smpl_cnt + 1'b1;
        end
    end

    assign voice.tick = &smpl_cnt;

endmodule

`default_nettype wire

//--- logic/pulse_osc.sv
// square wave only with SMPL_W of 8 or more so midscale plus amp cannot overflow
`timescale 1ns/1ps
`default_nettype none

module pulse_osc import synth_pkg::*; #(
    parameter int SMPL_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    voice_if.osc              voice,
    output logic [SMPL_W-1:0] smpl_l,
    output logic [SMPL_W-1:0] smpl_r
);

    localparam logic [SMPL_W-1:0] MID = SMPL_W'(1) << (SMPL_W - 1);

    logic [PHASE_W-1:0] phase;
    logic [PHASE_W-1:0] step;
    logic [PHASE_W-1:0] base;
    logic signed [14:0] bend_ofs;
    logic signed [31:0] bend_prod;
    logic               tick_d;

    // lower phase half adds amp and upper half subtracts
    function automatic logic [SMPL_W-1:0] level(input logic gate, input logic hi_half,
                                                 input logic [6:0] amp);
        if (!gate) begin
            return MID;
        end
        return hi_half ? MID - SMPL_W'(amp) : MID + SMPL_W'(amp);
    endfunction

    // bent step scales inc by the signed offset from center
    always_comb begin
        bend_ofs  = $signed({1'b0, voice.bend}) - $signed({1'b0, BEND_CENTER});
        bend_prod = 32'($signed({1'b0, voice.inc})) * 32'(bend_ofs);
        step      = voice.inc + PHASE_W'(bend_prod >>> 14);
        // restart together with tick still advances from zero
        base      = voice.restart ? '0 : phase;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= '0;
            tick_d <= 1'b0;
            smpl_l <= MID;
            smpl_r <= MID;
        end else begin
            tick_d <= voice.tick;
            if (voice.tick) begin
                phase <= base + step;
            end else if (voice.restart) begin
                phase <= '0;
            end
            // one cycle behind tick so the advanced phase is used
            if (tick_d) begin
                smpl_l <= level(voice.gate, phase[PHASE_W-1], voice.amp_l);
                smpl_r <= level(voice.gate, phase[PHASE_W-1], voice.amp_r);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/sd_dac.sv
// first order only so expect idle tones, needs an external rc low pass
`timescale 1ns/1ps
`default_nettype none

module sd_dac #(
    parameter int SMPL_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [SMPL_W-1:0] smpl,
    output logic              dac_out
);

    logic [SMPL_W-1:0] acc;
    logic [SMPL_W:0]   sum;

    // carry out is the pulse density bit
    assign sum = {1'b0, acc} + {1'b0, smpl};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc     <= '0;
            dac_out <= 1'b0;
        end else begin
            acc     <= sum[SMPL_W-1:0];
            dac_out <= sum[SMPL_W];
        end
    end

endmodule

`default_nettype wire

//--- logic/synth_top.sv
// no clock generation inside so clk must already run at the rate CLKS_PER_BIT was chosen for
`timescale 1ns/1ps
`default_nettype none

module synth_top #(
    parameter int         CLKS_PER_BIT = 8,
    parameter logic [3:0] MIDI_CH      = 4'd0,
    parameter int         SMPL_W       = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic dac_out_l,
    output logic dac_out_r
);

    logic              byte_rdy;
    logic [7:0]        byte_data;
    logic [SMPL_W-1:0] smpl_l;
    logic [SMPL_W-1:0] smpl_r;

    midi_msg_if msg_bus ();
    voice_if    voice_bus ();

    // ------------------------------------------------------------------------
    // serial in to messages
    // ------------------------------------------------------------------------
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .rx       (rx       ),
        .byte_rdy (byte_rdy ),
        .byte_data(byte_data)
    );

    midi_decoder #(.MIDI_CH(MIDI_CH)) midi_decoder_inst (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .byte_rdy (byte_rdy ),
        .byte_data(byte_data),
        .msg      (msg_bus  )
    );

    // ------------------------------------------------------------------------
    // voice and stereo output
    // ------------------------------------------------------------------------
    voice_ctrl #(.SMPL_W(SMPL_W)) voice_ctrl_inst (
        .clk  (clk      ),
        .rst_n(rst_n    ),
        .msg  (msg_bus  ),
        .voice(voice_bus)
    );

    pulse_osc #(.SMPL_W(SMPL_W)) pulse_osc_inst (
        .clk   (clk      ),
        .rst_n (rst_n    ),
        .voice (voice_bus),
        .smpl_l(smpl_l   ),
        .smpl_r(smpl_r   )
    );

    sd_dac #(.SMPL_W(SMPL_W)) sd_dac_l_inst (
        .clk    (clk      ),
        .rst_n  (rst_n    ),
        .smpl   (smpl_l   ),
        .dac_out(dac_out_l)
    );

    sd_dac #(.SMPL_W(SMPL_W)) sd_dac_r_inst (
        .clk    (clk      ),
        .rst_n  (rst_n    ),
        .smpl   (smpl_r   ),
        .dac_out(dac_out_r)
    );

endmodule

`default_nettype wire

//--- tests/synth_tb.sv
// serial MIDI in, ones counted per sample window on both outputs; assumes 8N1 at CLKS_PER_BIT
`timescale 1ns/1ps
`default_nettype none

module synth_tb import synth_pkg::*; ();

    localparam int         CLKS_PER_BIT = 8;
    localparam logic [3:0] MIDI_CH      = 4'd0;
    localparam int         SMPL_W       = 8;
    localparam int         WIN          = 1 << SMPL_W;
    localparam int         MID          = WIN / 2;
    // start, 8 data, stop and one idle bit
    localparam int         BYTE_CLKS    = 11 * CLKS_PER_BIT;
    // puts the message update in the middle of a sample period
    localparam int         ALIGN_AT     = MID + CLKS_PER_BIT - 1;
    localparam int         LIMIT_CYC    = (40 * 6 + 20) * WIN;

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        dac_out_l;
    logic        dac_out_r;
    logic [31:0] rng;
    int          cyc = 0;
    int          win_cnt = 0;
    int          ones_l = 0;
    int          ones_r = 0;
    int          errors = 0;
    int          exp_l_q[$];
    int          exp_r_q[$];

    // message handed from stimulus to the model
    logic [7:0]  pend_status;
    logic [7:0]  pend_d1;
    logic [7:0]  pend_d2;
    int          pend_seq;
    int          done_seq = 0;

    // voice state copy
    int          m_gate = 0;
    int          m_key = 0;
    int          m_vel = 0;
    int          m_pan = 64;
    int          m_inc = 0;
    int          m_bend = 8192;
    int          m_phase = 0;
    int          m_amp_l = 0;
    int          m_amp_r = 0;

    synth_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .MIDI_CH     (MIDI_CH     ),
        .SMPL_W      (SMPL_W      )
    ) UUT (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .rx       (rx       ),
        .dac_out_l(dac_out_l),
        .dac_out_r(dac_out_r)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // same count as the sample counter inside, zero in reset
    always @(posedge clk) begin
        if (rst_n) begin
            cyc <= cyc + 1;
        end
    end

    // -------------------------------------------------------------------------
    // reference model
    // -------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int pick_random(input int lo, input int span);
        rng = xorshift32(rng);
        return lo + int'(rng[23:0]) % span;
    endfunction

    // inc scaled by 1 + (bend - center) / 2^14, floor of the product
    function automatic int bent_step(input int inc, input int bend);
        int prod;
        prod = inc * (bend - 8192);
        return (inc + (prod >>> 14)) % 65536;
    endfunction

    function automatic int level(input int gate, input logic hi, input int amp);
        if (gate == 0) begin
            return MID;
        end
        return hi ? MID - amp : MID + amp;
    endfunction

    function automatic void update_amps();
        m_amp_l = (m_vel * (127 - m_pan)) / 128;
        m_amp_r = (m_vel * m_pan) / 128;
    endfunction

    function automatic void apply_msg(input logic [7:0] status, input logic [7:0] d1,
                                      input logic [7:0] d2);
        if (status[3:0] != MIDI_CH) begin
            return;
        end
        case (status[7:4])
            MIDI_NOTE_ON: begin
                if (d2 != 8'd0) begin
                    m_key   = int'(d1);
                    m_vel   = int'(d2);
                    m_inc   = int'(semitone_inc(d1[6:0]));
                    m_gate  = 1;
                    m_phase = 0;
                    update_amps();
                end else if (int'(d1) == m_key) begin
                    m_gate = 0;
                end
            end
            MIDI_NOTE_OFF: begin
                if (int'(d1) == m_key) begin
                    m_gate = 0;
                end
            end
            MIDI_CTRL: begin
                if (d1[6:0] == CC_PAN) begin
                    m_pan = int'(d2);
                    update_amps();
                end
            end
            MIDI_BEND: m_bend = int'(d1) + 128 * int'(d2);
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            errors = errors + 1;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // -------------------------------------------------------------------------
    // window counting and compare
    // -------------------------------------------------------------------------
    always @(negedge clk) begin
        if (pend_seq != done_seq) begin
            apply_msg(pend_status, pend_d1, pend_d2);
            done_seq = done_seq + 1;
        end
        if (rst_n) begin
            // tick edge just passed, phase advanced once
            if (cyc >= WIN && cyc % WIN == 0) begin
                m_phase = (m_phase + bent_step(m_inc, m_bend)) % 65536;
                exp_l_q.push_back(level(m_gate, m_phase >= 32768, m_amp_l));
                exp_r_q.push_back(level(m_gate, m_phase >= 32768, m_amp_r));
            end
            // two register stages behind the tick
            if (cyc >= WIN + 2) begin
                ones_l = ones_l + int'(dac_out_l);
                ones_r = ones_r + int'(dac_out_r);
                if ((cyc - WIN - 2) % WIN == WIN - 1) begin
                    if (exp_l_q.size() == 0 || exp_r_q.size() == 0) begin
                        $display("window ended with no expected value from the model");
                        $display("Something failed");
                        $fatal(1, "model out of step");
                    end
                    check_value("dac_out_l ones", ones_l, exp_l_q.pop_front());
                    check_value("dac_out_r ones", ones_r, exp_r_q.pop_front());
                    ones_l  = 0;
                    ones_r  = 0;
                    win_cnt = win_cnt + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= LIMIT_CYC) begin
            $display("timeout after %0d cycles, test sequence did not finish", cyc);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // -------------------------------------------------------------------------
    // stimulus, all tasks entered 1 ns after a rising edge
    // -------------------------------------------------------------------------
    task automatic drive_bit(input logic v);
        rx = v;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic uart_send(input logic [7:0] b, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop_bit);
        // idle bit so a low stop bit still leaves a falling edge
        drive_bit(1'b1);
    endtask

    task automatic send_bytes(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
                              input logic stop_bit);
        while ((cyc + 3 * BYTE_CLKS) % WIN != ALIGN_AT) begin
            @(posedge clk);
            #1;
        end
        uart_send(b0, stop_bit);
        uart_send(b1, stop_bit);
        uart_send(b2, stop_bit);
    endtask

    task automatic post_msg(input logic [7:0] s, input logic [7:0] d1, input logic [7:0] d2);
        pend_status = s;
        pend_d1     = d1;
        pend_d2     = d2;
        pend_seq    = pend_seq + 1;
    endtask

    task automatic wait_windows(input int n);
        int target;
        target = win_cnt + n;
        while (win_cnt < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic midi_msg(input logic [7:0] s, input logic [7:0] d1, input logic [7:0] d2);
        send_bytes(s, d1, d2, 1'b1);
        post_msg(s, d1, d2);
        wait_windows(8);
    endtask

    initial begin
        int key;
        int vel;
        int key2;
        int vel2;
        int bend;
        rx          = 1'b1;
        rst_n       = 1'b0;
        rng         = 32'd59819;
        pend_seq    = 0;
        pend_status = 8'h00;
        pend_d1     = 8'h00;
        pend_d2     = 8'h00;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle, midscale on both sides
        wait_windows(4);
        // high keys so the phase msb flips within a few windows
        key = pick_random(96, 32);
        vel = pick_random(1, 127);
        midi_msg(8'h90, 8'(key), 8'(vel));
        // pan then a fresh note
        midi_msg(8'hB0, 8'(CC_PAN), 8'(pick_random(0, 128)));
        key = pick_random(96, 32);
        vel = pick_random(1, 127);
        midi_msg(8'h90, 8'(key), 8'(vel));
        bend = pick_random(0, 16384);
        midi_msg(8'hE0, 8'(bend % 128), 8'(bend / 128));
        // releases, wrong key first
        midi_msg(8'h80, 8'(key ^ 1), 8'h40);
        midi_msg(8'h80, 8'(key), 8'h40);
        key = pick_random(96, 32);
        vel = pick_random(1, 127);
        midi_msg(8'h90, 8'(key), 8'(vel));
        midi_msg(8'h90, 8'(key), 8'h00);
        // other channel, gate stays low
        midi_msg(8'h91, 8'(key), 8'(vel));
        midi_msg(8'h90, 8'(key), 8'(vel));
        // running status note on with a clock byte in the middle
        key2 = pick_random(96, 32);
        vel2 = pick_random(1, 127);
        send_bytes(8'(key2), 8'hF8, 8'(vel2), 1'b1);
        post_msg(8'h90, 8'(key2), 8'(vel2));
        wait_windows(8);
        // note off with framing errors on every byte
        send_bytes(8'h80, 8'(key2), 8'h00, 1'b0);
        wait_windows(8);
        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- all.f
logic/synth_pkg.sv
logic/midi_msg_if.sv
logic/voice_if.sv
logic/uart_rx.sv
logic/midi_decoder.sv
logic/voice_ctrl.sv
logic/pulse_osc.sv
logic/sd_dac.sv
logic/synth_top.sv
tests/synth_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --top-module synth_tb -Mdir obj_dir -o synth_sim -f all.f &&
{ ./obj_dir/synth_sim > sim.log 2>&1 || true; } &&
grep -q "^Everything OK$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
